/* include/mul_defs.svh */
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand width used when the top level is not overridden
`define MUL_WIDTH_DEFAULT 32

// Byte address width of the Wishbone slave window
`define WB_ADDR_W 5

`endif

/* verilog/mul_pkg.sv */
`default_nettype none

`include "mul_defs.svh"

package mul_pkg;

   // Wishbone register map, byte offsets
   localparam logic [`WB_ADDR_W-1:0] REG_A      = 'h00; // Multiplier operand
   localparam logic [`WB_ADDR_W-1:0] REG_B      = 'h04; // Multiplicand operand
   localparam logic [`WB_ADDR_W-1:0] REG_CTRL   = 'h08; // Control on write, status on read
   localparam logic [`WB_ADDR_W-1:0] REG_RES_LO = 'h0C; // Product low word
   localparam logic [`WB_ADDR_W-1:0] REG_RES_HI = 'h10; // Product high word

   // Control register write bits
   localparam int CTRL_START_BIT = 0;
   localparam int CTRL_CLEAR_BIT = 1;

   // Control register read bits
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_DONE_BIT = 1;

   // Sequencer states
   typedef enum logic [1:0] {
      IDLE = 2'b00, // Waiting for a start
      LOAD = 2'b01, // Operands captured
      EXEC = 2'b10, // One recoding step per cycle
      DONE = 2'b11  // Product valid
   } mul_state_t;

endpackage

`default_nettype wire

/* verilog/booth_mul_top.sv */
`default_nettype none

`include "mul_defs.svh"

// Sequencer to counter and datapath handshake
interface mul_ctrl_if;
   logic load;  // Capture operands, zero the count
   logic step;  // One radix-4 step
   logic clear; // Abort and zero
   logic last;  // Final step in progress

   modport fsm (output load, step, clear, input last);
   modport cnt (input load, step, clear, output last);
   modport dp  (input load, step, clear);
endinterface

module booth_mul_top #(
   parameter int WIDTH = `MUL_WIDTH_DEFAULT
) (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`WB_ADDR_W-1:0]  adr,
   input  logic [WIDTH-1:0]       dat_w,
   output logic [WIDTH-1:0]       dat_r,
   output logic                   ack
);

   logic [WIDTH-1:0]   multiplier, multiplicand;
   logic [2*WIDTH-1:0] product;
   logic               start_pulse, clear_pulse;
   logic               busy, done;

   mul_ctrl_if ctl_if ();

   wb_mul_regs #(.WIDTH(WIDTH)) u_regs (
      .clk          (clk),
      .reset_n      (reset_n),
      .cyc          (cyc),
      .stb          (stb),
      .we           (we),
      .adr          (adr),
      .dat_w        (dat_w),
      .dat_r        (dat_r),
      .ack          (ack),
      .multiplier   (multiplier),
      .multiplicand (multiplicand),
      .start_pulse  (start_pulse),
      .clear_pulse  (clear_pulse),
      .busy         (busy),
      .done         (done),
      .product      (product)
   );

   mul_fsm u_fsm (
      .clk         (clk),
      .reset_n     (reset_n),
      .ctl         (ctl_if.fsm),
      .start_pulse (start_pulse),
      .clear_pulse (clear_pulse),
      .busy        (busy),
      .done        (done)
   );

   mul_step_counter #(.WIDTH(WIDTH)) u_cnt (
      .clk     (clk),
      .reset_n (reset_n),
      .ctl     (ctl_if.cnt)
   );

   booth_datapath #(.WIDTH(WIDTH)) u_dp (
      .clk          (clk),
      .reset_n      (reset_n),
      .ctl          (ctl_if.dp),
      .multiplier   (multiplier),
      .multiplicand (multiplicand),
      .product      (product)
   );

endmodule

`default_nettype wire

/* verilog/cla32.sv */
`default_nettype none

module cla32 #(
   parameter int WIDTH = 32
) (
   input  logic [WIDTH-1:0] a,
   input  logic [WIDTH-1:0] b,
   input  logic             cin,
   output logic [WIDTH-1:0] sum
);

   localparam int NG = (WIDTH + 3) / 4; // Number of four-bit groups
   localparam int PW = NG * 4;          // Width padded to whole groups

   logic [PW-1:0] a_x, b_x; // Zero-padded operands
   logic [PW-1:0] g, p;     // Bit generate and propagate
   logic [PW-1:0] s_x;      // Padded sum
   logic [NG:0]   gc;       // Carry into each group

   always_comb begin
      a_x = '0;
      b_x = '0;
      a_x[WIDTH-1:0] = a;
      b_x[WIDTH-1:0] = b;
   end

   assign g     = a_x & b_x;
   assign p     = a_x ^ b_x;
   assign gc[0] = cin;

   for (genvar gi = 0; gi < NG; gi++) begin : g_grp
      logic [3:0] gg, pp, cc;
      assign gg = g[4*gi +: 4];
      assign pp = p[4*gi +: 4];
      // Carries inside the group straight from generate/propagate
      assign cc[0] = gc[gi];
      assign cc[1] = gg[0] | (pp[0] & gc[gi]);
      assign cc[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & gc[gi]);
      assign cc[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                   | (pp[2] & pp[1] & pp[0] & gc[gi]);
      // Group carry out from group G and P
      assign gc[gi+1] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                      | (pp[3] & pp[2] & pp[1] & gg[0])
                      | (&pp & gc[gi]);
      assign s_x[4*gi +: 4] = pp ^ cc;
   end

   assign sum = s_x[WIDTH-1:0];

endmodule

`default_nettype wire

/* verilog/booth_datapath.sv */
`default_nettype none

module booth_datapath #(
   parameter int WIDTH = 32
) (
   input  logic                 clk,
   input  logic                 reset_n,
   mul_ctrl_if.dp               ctl,
   input  logic [WIDTH-1:0]     multiplier,
   input  logic [WIDTH-1:0]     multiplicand,
   output logic [2*WIDTH-1:0]   product
);

   // Two guard bits so that acc plus or minus 2M cannot overflow
   localparam int EW = WIDTH + 2;

   logic [EW-1:0]    acc;    // Upper partial product
   logic [WIDTH-1:0] mlt;    // Multiplier, shifted out as product low bits
   logic             q;      // Bit below the current pair
   logic [WIDTH-1:0] mcand;  // Captured multiplicand
   logic [EW-1:0]    m1, m2; // Sign-extended M and 2M
   logic [EW-1:0]    sum_p1, sum_p2, sum_m1, sum_m2;
   logic [EW-1:0]    part;   // Selected partial sum
   logic [2:0]       triple; // Booth recoding bits

   assign m1     = {{2{mcand[WIDTH-1]}}, mcand};
   assign m2     = {m1[EW-2:0], 1'b0};
   assign triple = {mlt[1:0], q};

   cla32 #(.WIDTH(EW)) u_add_m (
      .a   (acc),
      .b   (m1),
      .cin (1'b0),
      .sum (sum_p1)
   );

   cla32 #(.WIDTH(EW)) u_add_2m (
      .a   (acc),
      .b   (m2),
      .cin (1'b0),
      .sum (sum_p2)
   );

   cla32 #(.WIDTH(EW)) u_sub_m (
      .a   (acc),
      .b   (~m1),
      .cin (1'b1),
      .sum (sum_m1)
   );

   cla32 #(.WIDTH(EW)) u_sub_2m (
      .a   (acc),
      .b   (~m2),
      .cin (1'b1),
      .sum (sum_m2)
   );

   always_comb begin
      case (triple)
         3'b001, 3'b010: part = sum_p1; // +M
         3'b011:         part = sum_p2; // +2M
         3'b100:         part = sum_m2; // -2M
         3'b101, 3'b110: part = sum_m1; // -M
         default:        part = acc;    // 000 and 111 add nothing
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         acc <= '0;
         mlt <= '0;
         q   <= 1'b0;
      end else if (ctl.clear) begin // Abort wins over everything
         acc <= '0;
         mlt <= '0;
         q   <= 1'b0;
      end else if (ctl.load) begin
         acc <= '0;
         mlt <= multiplier;
         q   <= 1'b0;
      end else if (ctl.step) begin
         // Arithmetic shift right by two of {part, mlt}
         acc <= {{2{part[EW-1]}}, part[EW-1:2]};
         mlt <= {part[1:0], mlt[WIDTH-1:2]};
         q   <= mlt[1];
      end
   end

   always_ff @(posedge clk) begin
      if (ctl.load)
         mcand <= multiplicand;
   end

   assign product = {acc[WIDTH-1:0], mlt};

   // Operands are captured before the first recoding step, never during one
   a_no_load_step: assert property (@(posedge clk) disable iff (!reset_n)
      !(ctl.load && ctl.step));

endmodule

`default_nettype wire

/* verilog/mul_step_counter.sv */
`default_nettype none

module mul_step_counter #(
   parameter int WIDTH = 32
) (
   input  logic     clk,
   input  logic     reset_n,
   mul_ctrl_if.cnt  ctl
);

   localparam int STEPS = WIDTH / 2;      // One radix-4 step per bit pair
   localparam int CNT_W = $clog2(STEPS);

   logic [CNT_W-1:0] count;

   if (WIDTH % 2 != 0 || WIDTH < 8) begin : g_bad_width
      $error("booth multiplier needs an even WIDTH of 8 or more");
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n)
         count <= '0;
      else if (ctl.load || ctl.clear)
         count <= '0;
      else if (ctl.step)
         count <= count + 1'b1;
   end

   assign ctl.last = (count == CNT_W'(STEPS - 1)); // Terminal count

   // Sequencer must leave exec once the final step is taken
   a_no_step_past_last: assert property (@(posedge clk) disable iff (!reset_n)
      ctl.step && ctl.last |=> !ctl.step);

endmodule

`default_nettype wire

/* verilog/mul_fsm.sv */
`default_nettype none

module mul_fsm
   import mul_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   mul_ctrl_if.fsm  ctl,
   input  logic     start_pulse,
   input  logic     clear_pulse,
   output logic     busy,
   output logic     done
);

   mul_state_t state, state_nx;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n)
         state <= IDLE;
      else
         state <= state_nx;
   end

   always_comb begin
      state_nx = state;
      if (clear_pulse) begin // Clear beats start
         state_nx = IDLE;
      end else begin
         case (state)
            IDLE: if (start_pulse) state_nx = LOAD;
            LOAD: state_nx = EXEC;
            EXEC: if (ctl.step && ctl.last) state_nx = DONE;
            DONE: if (start_pulse) state_nx = LOAD; // Back-to-back run
            default: state_nx = IDLE;
         endcase
      end
   end

   assign ctl.load  = (state == LOAD);
   assign ctl.step  = (state == EXEC);
   assign ctl.clear = clear_pulse; // Same edge as the return to idle

   assign busy = (state == LOAD) || (state == EXEC);
   assign done = (state == DONE);

   // A step always follows a load or another step
   a_step_in_exec: assert property (@(posedge clk) disable iff (!reset_n)
      ctl.step |-> $past(ctl.load || ctl.step));

endmodule

`default_nettype wire

/* verilog/wb_mul_regs.sv */
`default_nettype none

`include "mul_defs.svh"

module wb_mul_regs
   import mul_pkg::*;
#(
   parameter int WIDTH = 32
) (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`WB_ADDR_W-1:0]  adr,
   input  logic [WIDTH-1:0]       dat_w,
   output logic [WIDTH-1:0]       dat_r,
   output logic                   ack,
   output logic [WIDTH-1:0]       multiplier,
   output logic [WIDTH-1:0]       multiplicand,
   output logic                   start_pulse,
   output logic                   clear_pulse,
   input  logic                   busy,
   input  logic                   done,
   input  logic [2*WIDTH-1:0]     product
);

   logic wr_en;   // Write strobe on the ack cycle
   logic wr_ctrl; // Write to the control register

   // Ack rises for one cycle after the request is seen
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n)
         ack <= 1'b0;
      else
         ack <= cyc && stb && !ack;
   end

   assign wr_en   = ack && cyc && stb && we;
   assign wr_ctrl = wr_en && (adr == REG_CTRL);

   // Operands stay frozen while a multiply runs
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         multiplier   <= '0;
         multiplicand <= '0;
      end else if (wr_en && !busy) begin
         if (adr == REG_A)
            multiplier <= dat_w;
         if (adr == REG_B)
            multiplicand <= dat_w;
      end
   end

   assign start_pulse = wr_ctrl && dat_w[CTRL_START_BIT];
   assign clear_pulse = wr_ctrl && dat_w[CTRL_CLEAR_BIT];

   // Read mux stays valid while the master holds adr up to ack
   always_comb begin
      dat_r = '0;
      case (adr)
         REG_A:      dat_r = multiplier;
         REG_B:      dat_r = multiplicand;
         REG_CTRL: begin
            dat_r[STAT_BUSY_BIT] = busy;
            dat_r[STAT_DONE_BIT] = done;
         end
         REG_RES_LO: dat_r = product[WIDTH-1:0];
         REG_RES_HI: dat_r = product[2*WIDTH-1:WIDTH];
         default:    dat_r = '0;
      endcase
   end

   // Every ack answers a request from the cycle before, still held by the master
   a_ack_after_req: assert property (@(posedge clk) disable iff (!reset_n)
      ack |-> $past(cyc && stb) && cyc && stb && $stable(adr) && $stable(we));

endmodule

`default_nettype wire

/* tests/mul_checker.sv */
`default_nettype none

`include "mul_defs.svh"

module mul_checker
   import mul_pkg::*;
#(
   parameter int WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  cyc,
   input  logic                  stb,
   input  logic                  we,
   input  logic [`WB_ADDR_W-1:0] adr,
   input  logic [WIDTH-1:0]      dat_w,
   input  logic [WIDTH-1:0]      dat_r,
   input  logic                  ack,
   input  logic                  busy,
   input  logic                  done
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NAME_W     = 8 * 16;
   localparam int DONE_CYCLE = WIDTH / 2 + 2; // Load, the steps, then done

   logic [WIDTH-1:0]  exp_q [$]; // Expected words of pending reads
   logic [NAME_W-1:0] cur_name;
   int                test_errs, tests_run, tests_failed, checks_failed;
   bit                timing_on;
   int                since_ack; // Cycles since the start ack

   task automatic begin_test(input logic [NAME_W-1:0] name);
      cur_name  = name;
      test_errs = 0;
      exp_q.delete();
   endtask

   task automatic expect_read(input logic [WIDTH-1:0] value);
      exp_q.push_back(value);
   endtask

   task automatic count_error();
      test_errs++;
      checks_failed++;
   endtask

   task automatic compare_read();
      logic [WIDTH-1:0] exp_word;
      exp_word = exp_q.pop_front();
      if (dat_r !== exp_word) begin
         $display("CHECK FAILED %0s: read of 0x%02h expected %h actual %h",
                  cur_name, adr, exp_word, dat_r);
         count_error();
      end
   endtask

   // Busy through the run, done and not busy exactly at DONE_CYCLE
   task automatic track_run();
      since_ack++;
      if (done) begin
         if (since_ack != DONE_CYCLE || busy) begin
            $display("%0s: done came %0d cycles after the start ack instead of %0d, busy %b",
                     cur_name, since_ack, DONE_CYCLE, busy);
            count_error();
         end
         timing_on = 1'b0;
      end else if (!busy || since_ack >= DONE_CYCLE) begin
         $display("%0s: %0d cycles after the start ack busy is %b and done is still low",
                  cur_name, since_ack, busy);
         count_error();
         timing_on = 1'b0;
      end
   endtask

   task automatic end_test();
      if (exp_q.size() != 0) begin
         $display("%0s: %0d expected reads never happened on the bus", cur_name, exp_q.size());
         count_error();
         exp_q.delete();
      end
      tests_run++;
      if (test_errs == 0) begin
         $display("PASS  %0s", cur_name);
      end else begin
         tests_failed++;
         $display("FAIL  %0s with %0d failed checks", cur_name, test_errs);
      end
   endtask

   task automatic print_summary(output int failures);
      $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
               tests_run, tests_run - tests_failed, tests_failed, checks_failed);
      failures = checks_failed;
   endtask

   // Sampled on the rising edge, where bus and status are settled
   always @(posedge clk) begin
      if (!reset_n) begin
         timing_on = 1'b0;
      end else begin
         if (timing_on)
            track_run();
         if (ack && cyc && stb && we && adr == REG_CTRL) begin
            if (dat_w[CTRL_CLEAR_BIT]) begin
               timing_on = 1'b0; // Aborted run never reaches done
            end else if (dat_w[CTRL_START_BIT] && !busy) begin
               timing_on = 1'b1;
               since_ack = 0;
            end
         end
         if (ack && cyc && stb && !we && exp_q.size() != 0)
            compare_read();
      end
   end

endmodule

`default_nettype wire

/* tests/tb_booth_mul.sv */
`default_nettype none

`include "mul_defs.svh"

module tb_booth_mul
   import mul_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WIDTH  = `MUL_WIDTH_DEFAULT;
   localparam int NAME_W = 8 * 16; // Names of up to 16 characters
   localparam int OP_W   = 8 * 12;
   localparam logic [OP_W-1:0] OP_MUL    = OP_W'("mul");
   localparam logic [OP_W-1:0] OP_ABORT  = OP_W'("abort");
   localparam logic [OP_W-1:0] OP_BUSYWR = OP_W'("busywrite");

   logic                  clk, reset_n, cyc, stb, we, ack;
   logic [`WB_ADDR_W-1:0] adr;
   logic [WIDTH-1:0]      dat_w, dat_r;
   int                    limit;  // Cycle limit, set once the tests are known
   int                    cycles;

   logic [NAME_W-1:0]  t_name [$];
   logic [OP_W-1:0]    t_op [$];
   logic [WIDTH-1:0]   t_a [$], t_b [$];
   logic [2*WIDTH-1:0] t_p [$];

   booth_mul_top #(.WIDTH(WIDTH)) u_dut (
      .clk     (clk),
      .reset_n (reset_n),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .dat_w   (dat_w),
      .dat_r   (dat_r),
      .ack     (ack)
   );

   mul_checker #(.WIDTH(WIDTH)) u_chk (
      .clk     (clk),
      .reset_n (reset_n),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .dat_w   (dat_w),
      .dat_r   (dat_r),
      .ack     (ack),
      .busy    (u_dut.busy), // Status straight from the sequencer
      .done    (u_dut.done)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Run stopped at the limit of %0d cycles, the DUT never finished", limit);
      $display("STATUS: FAIL");
      $finish;
   end

   // Wishbone classic cycle, held through the ack cycle
   task automatic bus_cycle(input logic write, input logic [`WB_ADDR_W-1:0] addr,
                            input logic [WIDTH-1:0] wdata, output logic [WIDTH-1:0] rdata);
      int gap;
      gap = int'($urandom % 2);
      repeat (gap) @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = addr;
      dat_w = wdata;
      @(negedge clk);
      while (!ack)
         @(negedge clk);
      rdata = dat_r;
      @(negedge clk); // Slave acts on the edge that ends the ack cycle
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_write(input logic [`WB_ADDR_W-1:0] addr, input logic [WIDTH-1:0] data);
      logic [WIDTH-1:0] rd;
      bus_cycle(1'b1, addr, data, rd);
   endtask

   task automatic checked_read(input logic [`WB_ADDR_W-1:0] addr, input logic [WIDTH-1:0] exp);
      logic [WIDTH-1:0] rd;
      u_chk.expect_read(exp);
      bus_cycle(1'b0, addr, '0, rd);
   endtask

   task automatic wait_done();
      logic [WIDTH-1:0] status;
      status = '0;
      while (!status[STAT_DONE_BIT])
         bus_cycle(1'b0, REG_CTRL, '0, status);
   endtask

   initial begin
      int fd, n, i, bad_ops;
      logic [NAME_W-1:0]  nm;
      logic [OP_W-1:0]    op;
      logic [WIDTH-1:0]   a, b;
      logic [2*WIDTH-1:0] p;
      logic [8*128-1:0]   skip;
      int                 failures;

      reset_n = 1'b0;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      dat_w   = '0;
      bad_ops = 0;
      void'($urandom(54));

      fd = $fopen("tests/mul_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open tests/mul_stimulus.txt");
      end else begin
         while ($fscanf(fd, "%s", nm) == 1) begin
            if (nm == NAME_W'("#")) begin
               void'($fgets(skip, fd)); // Column description
            end else begin
               n = $fscanf(fd, "%s %h %h %h", op, a, b, p);
               if (n == 4) begin
                  t_name.push_back(nm);
                  t_op.push_back(op);
                  t_a.push_back(a);
                  t_b.push_back(b);
                  t_p.push_back(p);
               end else begin
                  $display("Stimulus line of %0s is incomplete", nm);
                  bad_ops++;
               end
            end
         end
         $fclose(fd);
      end
      if (t_name.size() == 0)
         $display("No tests were read from the stimulus file");
      limit = (t_name.size() + 1) * 40 + 100;

      repeat (3) @(negedge clk);
      reset_n = 1'b1;

      u_chk.begin_test(NAME_W'("after_reset"));
      checked_read(REG_CTRL, '0);
      checked_read(REG_RES_LO, '0);
      checked_read(REG_RES_HI, '0);
      u_chk.end_test();

      for (i = 0; i < t_name.size(); i++) begin
         u_chk.begin_test(t_name[i]);
         bus_write(REG_A, t_a[i]);
         bus_write(REG_B, t_b[i]);
         bus_write(REG_CTRL, WIDTH'(1) << CTRL_START_BIT);
         if (t_op[i] == OP_ABORT) begin
            repeat (4) @(negedge clk); // Well inside the run
            bus_write(REG_CTRL, WIDTH'(1) << CTRL_CLEAR_BIT);
            checked_read(REG_CTRL, '0);
         end else begin
            if (t_op[i] == OP_BUSYWR) begin
               bus_write(REG_A, ~t_a[i]);
               bus_write(REG_B, ~t_b[i]);
               bus_write(REG_CTRL, WIDTH'(1) << CTRL_START_BIT);
            end else if (t_op[i] != OP_MUL) begin
               $display("Test %0s has an unknown operation", t_name[i]);
               bad_ops++;
            end
            wait_done();
         end
         checked_read(REG_RES_LO, t_p[i][WIDTH-1:0]);
         checked_read(REG_RES_HI, t_p[i][2*WIDTH-1:WIDTH]);
         u_chk.end_test();
      end

      u_chk.print_summary(failures);
      if (failures == 0 && bad_ops == 0 && t_name.size() > 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/mul_stimulus.txt */
# name op multiplier multiplicand expected_product
# operands are 32-bit hex, the product is the signed 64-bit result in hex, zero for abort
pos_times_pos   mul       00001234 00005678 0000000006260060
neg_times_pos   mul       FFFFFFF9 00000064 FFFFFFFFFFFFFD44
neg_times_neg   mul       FFFFFFFD FFFFFFFB 000000000000000F
zero_times_x    mul       00000000 12345678 0000000000000000
x_times_zero    mul       7FFFFFFF 00000000 0000000000000000
min_times_m1    mul       80000000 FFFFFFFF 0000000080000000
all_ones        mul       FFFFFFFF FFFFFFFF 0000000000000001
max_times_max   mul       7FFFFFFF 7FFFFFFF 3FFFFFFF00000001
min_times_min   mul       80000000 80000000 4000000000000000
min_times_max   mul       80000000 7FFFFFFF C000000080000000
abort_mid_run   abort     12345678 00000003 0000000000000000
after_abort     mul       000F4240 FFF0BDC0 FFFFFF172B5AF000
busy_writes     busywrite 00000019 FFFFFFEC FFFFFFFFFFFFFE0C
alt_bits_pos    mul       55555555 00000003 00000000FFFFFFFF
alt_bits_neg    mul       AAAAAAAA 00000003 FFFFFFFEFFFFFFFE
neg_big         mul       FFFF0000 00010000 FFFFFFFF00000000
pos_big         mul       00010000 00010000 0000000100000000
abort_again     abort     FFFFFFFF 7FFFFFFF 0000000000000000
one_times_min   mul       00000001 80000000 FFFFFFFF80000000

/* verilog.f */
+incdir+include
verilog/mul_pkg.sv
verilog/booth_mul_top.sv
verilog/cla32.sv
verilog/booth_datapath.sv
verilog/mul_step_counter.sv
verilog/mul_fsm.sv
verilog/wb_mul_regs.sv
tests/mul_checker.sv
tests/tb_booth_mul.sv

/* Makefile */
# Verilator build and run of the Booth multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_booth_mul
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
